// File: vlog.f
+incdir+include
hw/AesPkg.sv
hw/KeyExpander.sv
hw/AesRound.sv
hw/AesPipeline.sv
hw/AesTop.sv
verif/AesTb.sv

// File: verif/AesTb.sv
/*
 * Self-checking testbench for the AES-128 engine, with its own
 * reference cipher and an in-order output scoreboard
 */
`default_nettype none

module AesTb;
    localparam int TagWidth = 8;
    localparam int Timeout = 50;
    // Falling edge of drive to falling edge of dataOutValid
    localparam int Latency = 11;
    // Round keys 1 to 10 built one per clock
    localparam int ExpandCycles = 10;
    localparam logic [7:0] AffineConst = 8'h63;
    // FIPS-197 appendix C.1
    localparam logic [127:0] KnownKey = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] KnownPt = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] KnownCt = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic                Clock;
    logic                rst;
    logic [127:0]        key;
    logic                keyValid;
    logic                keyReady;
    logic [127:0]        dataIn;
    logic [TagWidth-1:0] dataInTag;
    logic                dataInValid;
    logic                dataInReady;
    logic [127:0]        dataOut;
    logic [TagWidth-1:0] dataOutTag;
    logic                dataOutValid;

    logic [7:0]          sboxTab [0:255];
    logic [127:0]        curKey;
    // Scoreboard queues hold one entry per accepted block
    logic [127:0]        expData [$];
    logic [TagWidth-1:0] expTag [$];
    int                  expEdge [$];
    int                  edgeCount;
    int                  errorCount;
    int                  checkCount;
    int                  cnt;

    AesTop #(
        .TagWidth (TagWidth)
    ) u_dut (
        .Clock        (Clock),
        .rst          (rst),
        .key          (key),
        .keyValid     (keyValid),
        .keyReady     (keyReady),
        .dataIn       (dataIn),
        .dataInTag    (dataInTag),
        .dataInValid  (dataInValid),
        .dataInReady  (dataInReady),
        .dataOut      (dataOut),
        .dataOutTag   (dataOutTag),
        .dataOutValid (dataOutValid)
    );

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        edgeCount <= edgeCount + 1;
    end

    // --------------------
    // Reference cipher
    // --------------------

    function automatic logic [7:0] gfDouble(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ {3'b000, a[7], a[7], 1'b0, a[7], a[7]};
    endfunction

    // S-box table built from log and antilog tables of generator 3
    task buildSboxTable;
        logic [7:0] expTab [0:255];
        logic [7:0] logTab [0:255];
        logic [7:0] p;
        logic [7:0] inv;
        p = 8'h01;
        for (int i = 0; i < 255; i++) begin
            expTab[i] = p;
            logTab[p] = i[7:0];
            p = p ^ gfDouble(p);
        end
        for (int i = 0; i < 256; i++) begin
            inv = (i == 0) ? 8'h00 : expTab[(255 - logTab[i]) % 255];
            for (int b = 0; b < 8; b++) begin
                sboxTab[i][b] = inv[b] ^ inv[(b + 4) % 8] ^ inv[(b + 5) % 8]
                              ^ inv[(b + 6) % 8] ^ inv[(b + 7) % 8] ^ AffineConst[b];
            end
        end
    endtask

    function automatic logic [127:0] aesEncryptRef(input logic [127:0] k,
                                                   input logic [127:0] pt);
        logic [7:0]   w [0:175];
        logic [7:0]   s [0:15];
        logic [7:0]   t [0:15];
        logic [7:0]   tmp [0:3];
        logic [7:0]   rcon;
        logic [7:0]   first;
        logic [7:0]   u;
        logic [127:0] ct;
        rcon = 8'h01;
        for (int i = 0; i < 16; i++) begin
            w[i] = k[127 - 8*i -: 8];
            s[i] = pt[127 - 8*i -: 8] ^ w[i];
        end
        // Key schedule expanded word by word
        for (int i = 4; i < 44; i++) begin
            for (int j = 0; j < 4; j++) begin
                tmp[j] = w[4*(i - 1) + j];
            end
            if (i % 4 == 0) begin
                first = tmp[0];
                tmp[0] = sboxTab[tmp[1]] ^ rcon;
                tmp[1] = sboxTab[tmp[2]];
                tmp[2] = sboxTab[tmp[3]];
                tmp[3] = sboxTab[first];
                rcon = gfDouble(rcon);
            end
            for (int j = 0; j < 4; j++) begin
                w[4*i + j] = w[4*(i - 4) + j] ^ tmp[j];
            end
        end
        for (int r = 1; r <= 10; r++) begin
            // Substitute and shift in one pass
            for (int c = 0; c < 4; c++) begin
                for (int row = 0; row < 4; row++) begin
                    t[4*c + row] = sboxTab[s[4*((c + row) % 4) + row]];
                end
            end
            for (int c = 0; c < 4; c++) begin
                u = t[4*c] ^ t[4*c + 1] ^ t[4*c + 2] ^ t[4*c + 3];
                for (int row = 0; row < 4; row++) begin
                    if (r < 10)
                        s[4*c + row] = t[4*c + row] ^ u
                                     ^ gfDouble(t[4*c + row] ^ t[4*c + (row + 1) % 4]);
                    else
                        s[4*c + row] = t[4*c + row];
                end
            end
            for (int i = 0; i < 16; i++) begin
                s[i] = s[i] ^ w[16*r + i];
            end
        end
        for (int i = 0; i < 16; i++) begin
            ct[127 - 8*i -: 8] = s[i];
        end
        return ct;
    endfunction

    function automatic logic [127:0] randomBlock();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // --------------------
    // Run control
    // --------------------

    task finishRun;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    endtask

    task timedOut(input string what);
        errorCount++;
        $display("Timed out after %0d cycles waiting for %s", Timeout, what);
        finishRun();
    endtask

    task waitKeyReady;
        int n;
        n = 0;
        while (!keyReady && n < Timeout) begin
            @(negedge Clock);
            n++;
        end
        if (!keyReady) timedOut("keyReady");
    endtask

    task drainPipeline;
        int n;
        n = 0;
        while (expData.size() != 0 && n < Timeout) begin
            @(negedge Clock);
            n++;
        end
        if (expData.size() != 0) timedOut("outstanding blocks");
    endtask

    // Offer one block for a cycle and queue its result if taken
    task driveBlock(input logic [127:0] data, input logic [TagWidth-1:0] tag,
                    input logic valid);
        dataIn = data;
        dataInTag = tag;
        dataInValid = valid;
        if (valid && dataInReady) begin
            expData.push_back(aesEncryptRef(curKey, data));
            expTag.push_back(tag);
            expEdge.push_back(edgeCount + Latency);
        end
        @(negedge Clock);
    endtask

    // Load a key and offer blocks until the expander finishes
    task loadKey(input logic [127:0] k);
        int n;
        waitKeyReady();
        key = k;
        keyValid = 1'b1;
        @(negedge Clock);
        keyValid = 1'b0;
        curKey = k;
        assert (!dataInReady) else begin
            errorCount++;
            $display("Error at %0t: dataInReady = %b, expected 0", $time, dataInReady);
        end
        n = 0;
        while (!dataInReady && n < Timeout) begin
            driveBlock(randomBlock(), 8'hee, 1'b1);
            n++;
        end
        dataInValid = 1'b0;
        if (!dataInReady) timedOut("dataInReady");
        assert (n == ExpandCycles) else begin
            errorCount++;
            $display("Error at %0t: dataInReady rose after %0d cycles, expected %0d",
                     $time, n, ExpandCycles);
        end
    endtask

    // --------------------
    // Output scoreboard
    // --------------------

    always @(negedge Clock) begin : compareOutputs
        logic [127:0]        wantData;
        logic [TagWidth-1:0] wantTag;
        int                  wantEdge;
        if (!rst && dataOutValid) begin
            assert (expData.size() != 0) else begin
                errorCount++;
                $display("Output at time %0t with no accepted block outstanding", $time);
            end
            if (expData.size() != 0) begin
                wantData = expData.pop_front();
                wantTag = expTag.pop_front();
                wantEdge = expEdge.pop_front();
                checkCount++;
                assert (dataOut == wantData) else begin
                    errorCount++;
                    $display("Error at %0t: dataOut = %h, expected %h",
                             $time, dataOut, wantData);
                end
                assert (dataOutTag == wantTag) else begin
                    errorCount++;
                    $display("Error at %0t: dataOutTag = %h, expected %h",
                             $time, dataOutTag, wantTag);
                end
                assert (edgeCount == wantEdge) else begin
                    errorCount++;
                    $display("Error at %0t: dataOutValid in cycle %0d, expected %0d",
                             $time, edgeCount, wantEdge);
                end
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        rst = 1'b1;
        key = '0;
        keyValid = 1'b0;
        dataIn = '0;
        dataInTag = '0;
        dataInValid = 1'b0;
        curKey = '0;
        edgeCount = 0;
        errorCount = 0;
        checkCount = 0;
        void'($urandom(32'h62af_f5ca));
        buildSboxTable();
        assert (aesEncryptRef(KnownKey, KnownPt) == KnownCt) else begin
            errorCount++;
            $display("Reference cipher disagrees with the FIPS-197 vector");
        end
        repeat (2) @(negedge Clock);
        rst = 1'b0;

        // Idle levels out of reset
        assert (keyReady) else begin
            errorCount++;
            $display("Error at %0t: keyReady = %b, expected 1", $time, keyReady);
        end
        assert (!dataInReady) else begin
            errorCount++;
            $display("Error at %0t: dataInReady = %b, expected 0", $time, dataInReady);
        end
        assert (!dataOutValid) else begin
            errorCount++;
            $display("Error at %0t: dataOutValid = %b, expected 0", $time, dataOutValid);
        end
        // No keys yet so this block must vanish
        driveBlock(randomBlock(), 8'hdd, 1'b1);
        dataInValid = 1'b0;

        // Known vector and single block latency
        loadKey(KnownKey);
        driveBlock(KnownPt, 8'h5a, 1'b1);
        dataInValid = 1'b0;
        cnt = 1;
        while (!dataOutValid && cnt < Timeout) begin
            @(negedge Clock);
            cnt++;
        end
        if (!dataOutValid) timedOut("dataOutValid");
        assert (cnt == Latency) else begin
            errorCount++;
            $display("Error at %0t: dataOutValid after %0d cycles, expected %0d",
                     $time, cnt, Latency);
        end
        assert (dataOut == KnownCt) else begin
            errorCount++;
            $display("Error at %0t: dataOut = %h, expected %h", $time, dataOut, KnownCt);
        end
        drainPipeline();

        // Back-to-back stream with key load locked out
        for (int i = 0; i < 40; i++) begin
            driveBlock(randomBlock(), i[TagWidth-1:0], 1'b1);
            assert (!keyReady) else begin
                errorCount++;
                $display("Error at %0t: keyReady = %b, expected 0", $time, keyReady);
            end
        end
        dataInValid = 1'b0;
        drainPipeline();

        // Fresh key after the drain
        loadKey(randomBlock());
        for (int i = 0; i < 20; i++) begin
            driveBlock(randomBlock(), 8'h80 + i[TagWidth-1:0], 1'b1);
        end
        dataInValid = 1'b0;
        drainPipeline();

        // Random gaps in dataInValid
        for (int i = 0; i < 40; i++) begin
            driveBlock(randomBlock(), 8'hc0 ^ i[TagWidth-1:0], $urandom() % 2);
        end
        dataInValid = 1'b0;
        drainPipeline();
        repeat (2) @(negedge Clock);
        finishRun();
    end

endmodule

`default_nettype wire

// File: hw/AesTop.sv
/*
 * AES-128 encryption engine top level: key expander, round pipeline,
 * and the key and data ready levels
 */
`default_nettype none

module AesTop #(
    parameter int TagWidth = 8
) (
    input  wire                 Clock,
    input  wire                 rst,

    // Key load
    input  wire [127:0]         key,
    input  wire                 keyValid,
    output logic                keyReady,

    // Plaintext in
    input  wire [127:0]         dataIn,
    input  wire [TagWidth-1:0]  dataInTag,
    input  wire                 dataInValid,
    output logic                dataInReady,

    // Ciphertext out, no back-pressure
    output logic [127:0]        dataOut,
    output logic [TagWidth-1:0] dataOutTag,
    output logic                dataOutValid
);
    import AesPkg::*;

    localparam int CountWidth = $clog2(PipeDepth + 1);

    aesRoundKeys           roundKeys;
    logic                  keysReady;
    logic                  expBusy;
    logic                  keyLoad;
    logic                  dataAccept;
    // Blocks between accept and dataOutValid
    logic [CountWidth-1:0] inFlight;

    // --------------------
    // Strobes and ready levels
    // --------------------

    assign keyLoad    = keyValid && keyReady;
    assign dataAccept = dataInValid && dataInReady;

    // Pipeline never stalls, so only the keys gate data
    assign dataInReady = keysReady;
    // New key only with the expander idle and the pipeline empty
    assign keyReady = !expBusy && (inFlight == '0);

    always_ff @(posedge Clock) begin
        if (rst) begin
            inFlight <= '0;
        end else begin
            case ({dataAccept, dataOutValid})
                2'b10: inFlight <= inFlight + 1'b1;
                2'b01: inFlight <= inFlight - 1'b1;
                default: inFlight <= inFlight;
            endcase
        end
    end

    KeyExpander uKeyExpander (
        .Clock     (Clock),
        .rst       (rst),
        .load      (keyLoad),
        .key       (key),
        .roundKeys (roundKeys),
        .keysReady (keysReady),
        .busy      (expBusy)
    );

    AesPipeline #(
        .TagWidth (TagWidth)
    ) uPipeline (
        .Clock     (Clock),
        .rst       (rst),
        .inValid   (dataAccept),
        .inBlock   (dataIn),
        .inTag     (dataInTag),
        .roundKeys (roundKeys),
        .outValid  (dataOutValid),
        .outBlock  (dataOut),
        .outTag    (dataOutTag)
    );

endmodule

`default_nettype wire

// File: hw/AesPipeline.sv
/*
 * Fully pipelined AES-128 datapath: key-add stage followed by ten
 * round stages, one block per clock, eleven cycles deep
 */
`default_nettype none

module AesPipeline #(
    parameter int TagWidth = 8
) (
    input  wire                      Clock,
    input  wire                      rst,
    input  wire                      inValid,
    input  wire AesPkg::aesBlock     inBlock,
    input  wire [TagWidth-1:0]       inTag,
    input  wire AesPkg::aesRoundKeys roundKeys,
    output logic                     outValid,
    output AesPkg::aesBlock          outBlock,
    output logic [TagWidth-1:0]      outTag
);
    import AesPkg::*;

    // Slot 0 is the key-add stage, slot r the output of round r
    logic                chainValid [0:NumRounds];
    aesBlock             chainState [0:NumRounds];
    logic [TagWidth-1:0] chainTag   [0:NumRounds];

    logic                addValid;
    aesBlock             addState;
    logic [TagWidth-1:0] addTag;

    // --------------------
    // Initial AddRoundKey
    // --------------------

    always_ff @(posedge Clock) begin
        addState <= inBlock ^ roundKeys[0];
        addTag <= inTag;
        if (rst) begin
            addValid <= 1'b0;
        end else begin
            addValid <= inValid;
        end
    end

    assign chainValid[0] = addValid;
    assign chainState[0] = addState;
    assign chainTag[0]   = addTag;

    // --------------------
    // Round stages 1..10
    // --------------------

    for (genvar r = 1; r <= NumRounds; r++) begin : genRound
        AesRound #(
            .TagWidth (TagWidth)
        ) uRound (
            .Clock      (Clock),
            .rst        (rst),
            .inValid    (chainValid[r-1]),
            .inState    (chainState[r-1]),
            .inTag      (chainTag[r-1]),
            .roundKey   (roundKeys[r]),
            .finalRound (r == NumRounds),
            .outValid   (chainValid[r]),
            .outState   (chainState[r]),
            .outTag     (chainTag[r])
        );
    end

    // Last round feeds the output directly
    assign outValid = chainValid[NumRounds];
    assign outBlock = chainState[NumRounds];
    assign outTag   = chainTag[NumRounds];

endmodule

`default_nettype wire

// File: hw/AesRound.sv
/*
 * One registered AES round: SubBytes, ShiftRows, optional MixColumns,
 * AddRoundKey, with valid and tag carried beside the state
 */
`default_nettype none

module AesRound #(
    parameter int TagWidth = 8
) (
    input  wire                  Clock,
    input  wire                  rst,

    // Upstream stage
    input  wire                  inValid,
    input  wire AesPkg::aesBlock inState,
    input  wire [TagWidth-1:0]   inTag,

    // Key for this round
    input  wire AesPkg::aesBlock roundKey,
    // Last round skips MixColumns
    input  wire                  finalRound,

    // Downstream stage
    output logic                 outValid,
    output AesPkg::aesBlock      outState,
    output logic [TagWidth-1:0]  outTag
);
    import AesPkg::*;

    aesBlock shifted;
    aesBlock mixed;

    // --------------------
    // Round datapath
    // --------------------

    // Byte substitution then row rotation
    assign shifted = shiftRows(subBytes(inState));

    // Column mix bypassed in round 10
    assign mixed = finalRound ? shifted : mixColumns(shifted);

    // --------------------
    // Stage register
    // --------------------

    always_ff @(posedge Clock) begin
        // AddRoundKey folded into the register input
        outState <= mixed ^ roundKey;
        outTag <= inTag;
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

endmodule

`default_nettype wire

// File: hw/KeyExpander.sv
/*
 * AES-128 key schedule, one round key per clock after a load strobe;
 * all eleven keys stay stored until the next load
 */
`default_nettype none

module KeyExpander (
    input  wire              Clock,
    input  wire              rst,
    input  wire              load,
    input  wire AesPkg::aesBlock key,
    output AesPkg::aesRoundKeys roundKeys,
    output logic             keysReady,
    output logic             busy
);
    import AesPkg::*;

    keyExpState state;
    // Index of the key written next, 1 to 10
    logic [3:0] roundCount;

    aesBlock    prevKey;
    aesBlock    nextKey;
    logic [31:0] rotWord;
    logic [31:0] subWord;
    logic [31:0] tempWord;

    // --------------------
    // Next key from previous
    // --------------------

    assign prevKey = roundKeys[roundCount - 4'd1];

    // RotWord on the last word of the previous key
    assign rotWord = {prevKey[23:0], prevKey[31:24]};

    // SubWord, byte by byte
    assign subWord = {sBox(rotWord[31:24]), sBox(rotWord[23:16]),
                      sBox(rotWord[15:8]), sBox(rotWord[7:0])};

    // Rcon only touches the top byte
    assign tempWord = subWord ^ {roundConst[roundCount - 4'd1], 24'h000000};

    // Each word chains on the one before it
    assign nextKey[127:96] = prevKey[127:96] ^ tempWord;
    assign nextKey[95:64]  = prevKey[95:64] ^ nextKey[127:96];
    assign nextKey[63:32]  = prevKey[63:32] ^ nextKey[95:64];
    assign nextKey[31:0]   = prevKey[31:0] ^ nextKey[63:32];

    // --------------------
    // Control FSM
    // --------------------

    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= keyIdle;
            roundCount <= 4'd1;
            keysReady <= 1'b0;
        end else if (load) begin
            // Restart from key 1, old keys no longer valid
            state <= keyExpanding;
            roundCount <= 4'd1;
            keysReady <= 1'b0;
        end else if (state == keyExpanding) begin
            if (roundCount == NumRounds) begin
                state <= keyIdle;
                keysReady <= 1'b1;
            end else begin
                roundCount <= roundCount + 4'd1;
            end
        end
    end

    // Key storage, cipher key on the load edge
    always_ff @(posedge Clock) begin
        if (load) begin
            roundKeys[0] <= key;
        end else if (state == keyExpanding) begin
            roundKeys[roundCount] <= nextKey;
        end
    end

    assign busy = (state == keyExpanding);

endmodule

`default_nettype wire

// File: hw/AesPkg.sv
/*
 * AES-128 shared package: block types, sizes, round constants,
 * key-expander states and the combinational transform functions
 */
`default_nettype none

package AesPkg;

    // --------------------
    // Sizes
    // --------------------

    // AES-128 round count
    localparam int NumRounds = 10;
    // Initial key-add stage plus one stage per round
    localparam int PipeDepth = NumRounds + 1;

    // --------------------
    // Types
    // --------------------

    // State or data block, byte 0 in bits 127:120
    typedef logic [127:0] aesBlock;

    // Round key r lives in slice r, slice 0 is the cipher key
    typedef aesBlock [NumRounds:0] aesRoundKeys;

    // Key expander FSM
    typedef enum logic {
        keyIdle,
        keyExpanding
    } keyExpState;

    // --------------------
    // Constants
    // --------------------

    // Rcon bytes for rounds 1 to 10
    localparam logic [7:0] roundConst [0:NumRounds-1] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // Transform functions, typed on aesBlock above
    `include "AesFunctions.svh"

endpackage

`default_nettype wire

// File: include/AesFunctions.svh
/*
 * AES-128 combinational helpers: GF(2^8) arithmetic, S-box,
 * and the SubBytes, ShiftRows and MixColumns block transforms
 */
`ifndef AES_FUNCTIONS_SVH
`define AES_FUNCTIONS_SVH

// --------------------
// Field arithmetic
// --------------------

// Multiply by x modulo the AES polynomial 0x11b
function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
endfunction

// Shift-and-add multiply, one xtime per bit of b
function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] term;
    acc = 8'h00;
    term = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            acc = acc ^ term;
        end
        term = xtime(term);
    end
    return acc;
endfunction

// Forward S-box: inverse as a^254, then the affine map
function automatic logic [7:0] sBox(input logic [7:0] a);
    logic [7:0] pow;
    logic [7:0] inv;
    pow = a;
    inv = 8'h01;
    // 254 = 2+4+...+128, so multiply the successive squares
    for (int i = 1; i < 8; i++) begin
        pow = gfMul(pow, pow);
        inv = gfMul(inv, pow);
    end
    // Zero maps to zero here, giving 0x63 after the affine step
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
               ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// --------------------
// Block transforms
// --------------------

function automatic aesBlock subBytes(input aesBlock b);
    aesBlock res;
    for (int i = 0; i < 16; i++) begin
        res[8*i +: 8] = sBox(b[8*i +: 8]);
    end
    return res;
endfunction

// Byte k = 4*col + row, byte 0 in the top bits
function automatic aesBlock shiftRows(input aesBlock b);
    aesBlock res;
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            res[127 - 8*(4*c + r) -: 8] = b[127 - 8*(4*((c + r) % 4) + r) -: 8];
        end
    end
    return res;
endfunction

// Column times the fixed matrix {02 03 01 01} rotated
function automatic aesBlock mixColumns(input aesBlock b);
    aesBlock res;
    logic [7:0] a0, a1, a2, a3;
    for (int c = 0; c < 4; c++) begin
        {a0, a1, a2, a3} = b[127 - 32*c -: 32];
        res[127 - 32*c -: 32] = {
            xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    end
    return res;
endfunction

`endif
